//--- sources.f
+incdir+verification
hdl/boardBusPkg.sv
hdl/boardMapPkg.sv
hdl/cpuBus.sv
hdl/mainBusDecoder.sv
hdl/subBusDecoder.sv
hdl/sharedRamArbiter.sv
hdl/boardControlRegs.sv
hdl/dualCpuBoard.sv
verification/dualCpuBoardTb.sv

//--- Makefile
# Verilator build and run of the dual CPU board testbench
TOP = dualCpuBoardTb

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- verification/tbCases.svh
// Dual CPU board test steps
// Columns: name, bus, write, addr, wdata, read check, rdata, selects, irq vector, pulse
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

localparam int numCases = 25;

localparam step_t cases [numCases] = '{
	'{"ram main wr", busMain, 1'b1, 16'h0010, 8'hA5, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"ram sub rd", busSub, 1'b0, 16'h0010, 8'h00, chkTab, 8'hA5, 7'h00, 5'h00, pulseNone},
	'{"ram sub wr", busSub, 1'b1, 16'h1FF0, 8'h3C, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"ram main rd", busMain, 1'b0, 16'h1FF0, 8'h00, chkTab, 8'h3C, 7'h00, 5'h00, pulseNone},
	'{"map rd", busMain, 1'b0, 16'h2000, 8'h00, chkExt, 8'h00, 7'h01, 5'h00, pulseNone},
	'{"back1 wr", busMain, 1'b1, 16'h2800, 8'h11, chkNone, 8'h00, 7'h02, 5'h00, pulseNone},
	'{"back2 rd", busMain, 1'b0, 16'h3000, 8'h00, chkExt, 8'h00, 7'h04, 5'h00, pulseNone},
	'{"obj wr", busMain, 1'b1, 16'h3800, 8'h22, chkNone, 8'h00, 7'h08, 5'h00, pulseNone},
	'{"io rd", busMain, 1'b0, 16'h3A00, 8'h00, chkExt, 8'h00, 7'h10, 5'h00, pulseNone},
	'{"pal wr", busMain, 1'b1, 16'h3C00, 8'h33, chkNone, 8'h00, 7'h20, 5'h00, pulseNone},
	'{"rom rd", busMain, 1'b0, 16'h4000, 8'h00, chkExt, 8'h00, 7'h40, 5'h00, pulseNone},
	'{"vblank nmi", busMain, 1'b0, 16'h0000, 8'h00, chkNone, 8'h00, 7'h00, 5'h01, pulseVblank},
	'{"nmi ack", busMain, 1'b1, 16'h3A09, 8'h00, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"ims firq", busMain, 1'b0, 16'h0000, 8'h00, chkNone, 8'h00, 7'h00, 5'h04, pulseIms},
	'{"firq ack", busMain, 1'b1, 16'h3A0A, 8'h00, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"sub raise irq", busSub, 1'b1, 16'h2000, 8'h00, chkNone, 8'h00, 7'h00, 5'h02, pulseNone},
	'{"irq ack", busMain, 1'b1, 16'h3A0B, 8'h00, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"main raise sub", busMain, 1'b1, 16'h3A0C, 8'h00, chkNone, 8'h00, 7'h00, 5'h08, pulseNone},
	'{"sub irq ack", busSub, 1'b1, 16'h2FFF, 8'h00, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"bank set", busSub, 1'b1, 16'h3000, 8'h01, chkNone, 8'h00, 7'h00, 5'h10, pulseNone},
	'{"bank clear", busSub, 1'b1, 16'h37FF, 8'hFE, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"both wr", busBoth, 1'b1, 16'h0100, 8'h5A, chkNone, 8'h00, 7'h00, 5'h00, pulseNone},
	'{"both rd main", busMain, 1'b0, 16'h0100, 8'h00, chkTab, 8'h5A, 7'h00, 5'h00, pulseNone},
	'{"both rd sub", busSub, 1'b0, 16'h0101, 8'h00, chkTab, 8'hA5, 7'h00, 5'h00, pulseNone},
	'{"sub rom rd", busSub, 1'b0, 16'h8000, 8'h00, chkTab, 8'hFF, 7'h00, 5'h00, pulseNone}
};

`endif

//--- verification/dualCpuBoardTb.sv
// Dual CPU board testbench
// Table driven main and sub bus steps with data, select and interrupt checks
`default_nettype none
`timescale 1ns/1ps

module dualCpuBoardTb;

	localparam logic [1:0] busMain = 2'd0;
	localparam logic [1:0] busSub = 2'd1;
	localparam logic [1:0] busBoth = 2'd2;  // Same cycle, sub at addr ^ 1 with inverted data
	localparam logic [1:0] chkNone = 2'd0;
	localparam logic [1:0] chkTab = 2'd1;   // Table rdata
	localparam logic [1:0] chkExt = 2'd2;   // External device model
	localparam logic [1:0] pulseNone = 2'd0;
	localparam logic [1:0] pulseVblank = 2'd1;
	localparam logic [1:0] pulseIms = 2'd2;
	localparam logic [31:0] seed = 32'haa48_2679;

	typedef struct packed {
		logic [127:0] name;
		logic [1:0] bus;
		logic write;
		logic [15:0] addr;
		logic [7:0] wdata;
		logic [1:0] rdChk;
		logic [7:0] rdata;
		logic [6:0] sel;   // {rom, pal, io, obj, back2, back1, map}
		logic [4:0] irq;   // {bank, subIrq, firq, irq, nmi} after the step
		logic [1:0] pulse;
	} step_t;

	`include "tbCases.svh"

	logic clk = 1'b0;
	logic reset;
	logic mainValid, mainWrite, mainReady;
	logic [15:0] mainAddr;
	logic [7:0] mainWdata, mainRdata;
	logic subValid, subWrite, subReady;
	logic [15:0] subAddr;
	logic [7:0] subWdata, subRdata;
	logic extWrite;
	logic [7:0] extWdata, extRdata;
	logic mapSel, back1Sel, back2Sel, objSel, ioSel, palSel, romSel;
	logic mainNmi, mainIrq, mainFirq, subIrq, subRomBank;
	logic vblank, ims;
	logic [6:0] selVec;
	logic [4:0] irqVec;
	int errors;
	int checks;

	assign selVec = {romSel, palSel, ioSel, objSel, back2Sel, back1Sel, mapSel};
	assign irqVec = {subRomBank, subIrq, mainFirq, mainIrq, mainNmi};

	dualCpuBoard u_dut (.*);

	always #20 clk = ~clk; // 40 ns period

	//******************************
	// Helpers
	//******************************
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// External read data, whole address folded into the seed
	function automatic logic [7:0] extValue(input logic [15:0] addr);
		logic [31:0] r;
		r = xorshift(xorshift(seed ^ {16'h0000, addr}));
		return r[7:0];
	endfunction

	function automatic string nameText(input logic [127:0] raw);
		string s;
		s = "";
		for (int i = 15; i >= 0; i--)
			if (raw[i*8 +: 8] != 8'h00) s = {s, $sformatf("%c", raw[i*8 +: 8])}; // Skip padding
		return s;
	endfunction

	task automatic checkEqual(input logic [127:0] name, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", nameText(name), what, expected, actual);
		end
	endtask

	task automatic runStep(input step_t c);
		logic mainPend;
		logic subPend;
		logic [6:0] sawSel;
		logic [7:0] gotMain;
		logic [7:0] gotSub;
		logic gotExtWr;
		logic [7:0] gotExtData;
		logic [7:0] expRd;
		int settle;
		if (c.pulse != pulseNone) begin // One cycle input pulse ahead of the access
			@(posedge clk);
			vblank <= c.pulse == pulseVblank;
			ims <= c.pulse == pulseIms;
			@(posedge clk);
			vblank <= 1'b0;
			ims <= 1'b0;
		end
		@(posedge clk);
		mainPend = c.bus != busSub;
		subPend = c.bus != busMain;
		mainValid <= mainPend;
		mainWrite <= c.write;
		mainAddr <= c.addr;
		mainWdata <= c.wdata;
		extRdata <= extValue(c.addr);
		subValid <= subPend;
		subWrite <= c.write;
		subAddr <= c.bus == busBoth ? c.addr ^ 16'h0001 : c.addr;
		subWdata <= c.bus == busBoth ? ~c.wdata : c.wdata;
		sawSel = '0;
		gotMain = '0;
		gotSub = '0;
		gotExtWr = 1'b0;
		gotExtData = '0;
		while (mainPend || subPend) begin
			@(negedge clk);
			sawSel |= selVec; // Selects seen anywhere in the access
			if (mainPend && mainReady) begin
				mainPend = 1'b0;
				gotMain = mainRdata;
				gotExtWr = extWrite;
				gotExtData = extWdata;
			end
			if (subPend && subReady) begin
				subPend = 1'b0;
				gotSub = subRdata;
			end
			@(posedge clk);
			if (!mainPend) mainValid <= 1'b0; // Held until its own ready
			if (!subPend) subValid <= 1'b0;
		end
		expRd = c.rdChk == chkExt ? extValue(c.addr) : c.rdata;
		if (c.rdChk != chkNone)
			checkEqual(c.name, "rdata", expRd, c.bus == busSub ? gotSub : gotMain);
		checkEqual(c.name, "selects", {1'b0, c.sel}, {1'b0, sawSel});
		if (c.bus != busSub) begin
			checkEqual(c.name, "extWrite", {7'b0, c.write && c.sel != '0}, {7'b0, gotExtWr});
			if (c.write && c.sel != '0) checkEqual(c.name, "extWdata", c.wdata, gotExtData);
		end
		// Latches settle a few cycles after the op or edge
		settle = 0;
		@(negedge clk);
		while (irqVec !== c.irq && settle < 6) begin
			@(negedge clk);
			settle++;
		end
		checkEqual(c.name, "irq/bank", {3'b0, c.irq}, {3'b0, irqVec});
	endtask

	//******************************
	// Main sequence
	//******************************
	initial begin
		errors = 0;
		checks = 0;
		reset <= 1'b1;
		mainValid <= 1'b0;
		mainWrite <= 1'b0;
		mainAddr <= '0;
		mainWdata <= '0;
		subValid <= 1'b0;
		subWrite <= 1'b0;
		subAddr <= '0;
		subWdata <= '0;
		extRdata <= '0;
		vblank <= 1'b0;
		ims <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkEqual("reset", "selects", 8'h00, {1'b0, selVec}); // Everything quiet after reset
		checkEqual("reset", "irq/bank", 8'h00, {3'b0, irqVec});
		checkEqual("reset", "ready/extWrite", 8'h00, {5'b0, extWrite, mainReady, subReady});
		for (int i = 0; i < numCases; i++) runStep(cases[i]);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog, 20 cycles of 40 ns per table step
	initial begin
		#(numCases * 20 * 40);
		errors++;
		$display("Timeout after %0d ns, the step table did not finish", numCases * 20 * 40);
		$display("%0d checks, %0d errors", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/dualCpuBoard.sv
// Dual CPU board glue
// Main and sub decoders, shared SRAM arbiter and control registers
`default_nettype none
`timescale 1ns/1ps

module dualCpuBoard (
	input wire clk,
	input wire reset,
	input wire mainValid,
	input wire mainWrite,
	input wire boardBusPkg::addr_t mainAddr,
	input wire boardBusPkg::data_t mainWdata,
	output boardBusPkg::data_t mainRdata,
	output logic mainReady,
	input wire subValid,
	input wire subWrite,
	input wire boardBusPkg::addr_t subAddr,
	input wire boardBusPkg::data_t subWdata,
	output boardBusPkg::data_t subRdata,
	output logic subReady,
	output logic extWrite,
	output boardBusPkg::data_t extWdata,
	input wire boardBusPkg::data_t extRdata,
	output logic mapSel,
	output logic back1Sel,
	output logic back2Sel,
	output logic objSel,
	output logic ioSel,
	output logic palSel,
	output logic romSel,
	output logic mainNmi,
	output logic mainIrq,
	output logic mainFirq,
	output logic subIrq,
	input wire vblank,
	input wire ims,
	output logic subRomBank
);

	cpuBus mainRam ();
	cpuBus subRam ();

	logic mainCtrlValid;
	boardBusPkg::ctrlOp_t mainCtrlOp;
	logic subCtrlValid;
	boardBusPkg::ctrlOp_t subCtrlOp;
	logic subCtrlData;

	mainBusDecoder u_mainDec (
		.clk(clk), .reset(reset),
		.mainValid(mainValid), .mainWrite(mainWrite),
		.mainAddr(mainAddr), .mainWdata(mainWdata), .extRdata(extRdata),
		.mainRdata(mainRdata), .mainReady(mainReady),
		.extWrite(extWrite), .extWdata(extWdata),
		.mapSel(mapSel), .back1Sel(back1Sel), .back2Sel(back2Sel),
		.objSel(objSel), .ioSel(ioSel), .palSel(palSel), .romSel(romSel),
		.ram(mainRam.requester),
		.ctrlValid(mainCtrlValid), .ctrlOp(mainCtrlOp),
		.ctrlData() // Main strobes carry no data
	);

	subBusDecoder u_subDec (
		.clk(clk), .reset(reset),
		.subValid(subValid), .subWrite(subWrite),
		.subAddr(subAddr), .subWdata(subWdata),
		.subRdata(subRdata), .subReady(subReady),
		.ram(subRam.requester),
		.ctrlValid(subCtrlValid), .ctrlOp(subCtrlOp), .ctrlData(subCtrlData)
	);

	sharedRamArbiter u_arb (
		.clk(clk), .reset(reset),
		.mainPort(mainRam.server),
		.subPort(subRam.server)
	);

	boardControlRegs u_ctrl (
		.clk(clk), .reset(reset),
		.vblank(vblank), .ims(ims),
		.mainCtrlValid(mainCtrlValid), .mainCtrlOp(mainCtrlOp),
		.subCtrlValid(subCtrlValid), .subCtrlOp(subCtrlOp), .subCtrlData(subCtrlData),
		.mainNmi(mainNmi), .mainIrq(mainIrq), .mainFirq(mainFirq),
		.subIrq(subIrq), .subRomBank(subRomBank)
	);

endmodule

`default_nettype wire

//--- hdl/boardControlRegs.sv
// Board control registers
// Main and sub interrupt latches, input edge detect, sub ROM bank bit
`default_nettype none
`timescale 1ns/1ps

module boardControlRegs (
	input wire clk,
	input wire reset,
	input wire vblank,
	input wire ims,
	input wire mainCtrlValid,
	input wire boardBusPkg::ctrlOp_t mainCtrlOp,
	input wire subCtrlValid,
	input wire boardBusPkg::ctrlOp_t subCtrlOp,
	input wire subCtrlData,
	output logic mainNmi,
	output logic mainIrq,
	output logic mainFirq,
	output logic subIrq,
	output logic subRomBank
);

	logic vblankS, vblankQ; // Sampled and delayed copies
	logic imsS, imsQ;
	// Latch order: 0 NMI, 1 IRQ, 2 FIRQ, 3 sub IRQ
	logic [3:0] irqSet;
	logic [3:0] irqClr;
	logic [3:0] irqLatch;

	//******************************
	// Set and clear sources
	//******************************
	always_comb begin
		irqSet[0] = vblankS && !vblankQ; // vblank rising
		irqSet[1] = subCtrlValid && subCtrlOp == boardBusPkg::mainIrqRaise;
		irqSet[2] = imsS && !imsQ; // ims rising
		irqSet[3] = mainCtrlValid && mainCtrlOp == boardBusPkg::subIrqRaise;
		irqClr[0] = mainCtrlValid && mainCtrlOp == boardBusPkg::nmiAck;
		irqClr[1] = mainCtrlValid && mainCtrlOp == boardBusPkg::irqAck;
		irqClr[2] = mainCtrlValid && mainCtrlOp == boardBusPkg::firqAck;
		irqClr[3] = subCtrlValid && subCtrlOp == boardBusPkg::subIrqAck;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vblankS <= 1'b0;
			vblankQ <= 1'b0;
			imsS <= 1'b0;
			imsQ <= 1'b0;
			irqLatch <= 4'b0;
			subRomBank <= 1'b0;
		end else begin
			vblankS <= vblank;
			vblankQ <= vblankS;
			imsS <= ims;
			imsQ <= imsS;
			irqLatch <= (irqLatch | irqSet) & ~irqClr; // Clear wins
			if (subCtrlValid && subCtrlOp == boardBusPkg::bankLoad)
				subRomBank <= subCtrlData;
		end
	end

	assign {subIrq, mainFirq, mainIrq, mainNmi} = irqLatch;

endmodule

`default_nettype wire

//--- hdl/sharedRamArbiter.sv
// Shared SRAM arbiter
// 8Kx8 array serving main and sub requests, alternating on contention
`default_nettype none
`timescale 1ns/1ps

module sharedRamArbiter (
	input wire clk,
	input wire reset,
	cpuBus.server mainPort,
	cpuBus.server subPort
);

	boardBusPkg::arbState_t state; // arbServe means array access this cycle
	logic lastSub; // Last grant went to sub
	logic gSub; // Port in service
	logic gWrite;
	boardBusPkg::ramAddr_t gAddr;
	boardBusPkg::data_t gData;
	boardBusPkg::data_t rdReg;
	logic mainReady;
	logic subReady;
	logic mainReq;
	logic subReq;
	logic grant;
	logic pickSub;
	boardBusPkg::data_t mem [0:(1 << boardBusPkg::ramAddrW) - 1];

	//******************************
	// Request filter and tie break
	//******************************
	always_comb begin
		// Skip a port that is being served or answered, its valid is still up
		mainReq = mainPort.valid && !mainReady && !(state == boardBusPkg::arbServe && !gSub);
		subReq = subPort.valid && !subReady && !(state == boardBusPkg::arbServe && gSub);
		grant = mainReq || subReq;
		pickSub = subReq && (!mainReq || !lastSub); // Tie goes to the other side
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= boardBusPkg::arbIdle;
			lastSub <= 1'b1; // Main wins first tie
			mainReady <= 1'b0;
			subReady <= 1'b0;
		end else begin
			state <= grant ? boardBusPkg::arbServe : boardBusPkg::arbIdle;
			if (grant) lastSub <= pickSub;
			mainReady <= state == boardBusPkg::arbServe && !gSub; // Pulse after serve
			subReady <= state == boardBusPkg::arbServe && gSub;
		end
	end

	// Granted request captured for its serve cycle
	always_ff @(posedge clk) begin
		if (grant) begin
			gSub <= pickSub;
			gWrite <= pickSub ? subPort.write : mainPort.write;
			gAddr <= pickSub ? subPort.addr[boardBusPkg::ramAddrW-1:0]
				: mainPort.addr[boardBusPkg::ramAddrW-1:0];
			gData <= pickSub ? subPort.wdata : mainPort.wdata;
		end
	end

	//******************************
	// SRAM array
	//******************************
	always_ff @(posedge clk) begin
		if (state == boardBusPkg::arbServe) begin
			if (gWrite) mem[gAddr] <= gData;
			rdReg <= mem[gAddr]; // Old data on writes, unused
		end
	end

	assign mainPort.ready = mainReady;
	assign subPort.ready = subReady;
	assign mainPort.rdata = rdReg; // Only meaningful with ready
	assign subPort.rdata = rdReg;

endmodule

`default_nettype wire

//--- hdl/subBusDecoder.sv
// Sub CPU address decoder
// Shared RAM, control block writes, idle bus everywhere else
`default_nettype none
`timescale 1ns/1ps

module subBusDecoder (
	input wire clk,
	input wire reset,
	input wire subValid,
	input wire subWrite,
	input wire boardBusPkg::addr_t subAddr,
	input wire boardBusPkg::data_t subWdata,
	output boardBusPkg::data_t subRdata,
	output logic subReady,
	cpuBus.requester ram,
	output logic ctrlValid,
	output boardBusPkg::ctrlOp_t ctrlOp,
	output logic ctrlData
);

	logic isRam;
	logic inMainIrq, inIrqAck, inBank; // 2K control blocks
	logic isCtrl;
	logic busy;
	logic curCtrl;
	logic issue;

	assign isRam = subAddr <= boardMapPkg::ramTop;
	assign inMainIrq = subAddr[15:11] == boardMapPkg::mainIrqBase[15:11];
	assign inIrqAck = subAddr[15:11] == boardMapPkg::subIrqAckBase[15:11];
	assign inBank = subAddr[15:11] == boardMapPkg::bankBase[15:11];
	assign isCtrl = subWrite && (inMainIrq || inIrqAck || inBank); // Reads there float

	assign issue = subValid && !busy && !isRam;

	always_ff @(posedge clk) begin
		if (reset) busy <= 1'b0;
		else busy <= issue;
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			curCtrl <= isCtrl;
			ctrlData <= subWdata[0]; // Bank bit
			if (inMainIrq) ctrlOp <= boardBusPkg::mainIrqRaise;
			else if (inIrqAck) ctrlOp <= boardBusPkg::subIrqAck;
			else ctrlOp <= boardBusPkg::bankLoad;
		end
	end

	assign ctrlValid = busy && curCtrl;

	assign ram.valid = subValid && isRam;
	assign ram.write = subWrite;
	assign ram.addr = subAddr;
	assign ram.wdata = subWdata;

	assign subReady = busy || ram.ready;
	assign subRdata = ram.ready ? ram.rdata : boardBusPkg::busIdle; // No sub ROM here

endmodule

`default_nettype wire

//--- hdl/mainBusDecoder.sv
// Main CPU address decoder
// Routes main requests to shared RAM, control strobes or the external selects
`default_nettype none
`timescale 1ns/1ps

module mainBusDecoder (
	input wire clk,
	input wire reset,
	input wire mainValid,
	input wire mainWrite,
	input wire boardBusPkg::addr_t mainAddr,
	input wire boardBusPkg::data_t mainWdata,
	input wire boardBusPkg::data_t extRdata,
	output boardBusPkg::data_t mainRdata,
	output logic mainReady,
	output logic extWrite,
	output boardBusPkg::data_t extWdata,
	output logic mapSel,
	output logic back1Sel,
	output logic back2Sel,
	output logic objSel,
	output logic ioSel,
	output logic palSel,
	output logic romSel,
	cpuBus.requester ram,
	output logic ctrlValid,
	output boardBusPkg::ctrlOp_t ctrlOp,
	output logic ctrlData
);

	boardMapPkg::mainRegion_t region;
	boardMapPkg::mainRegion_t curRegion; // Region of access in flight
	boardBusPkg::ctrlOp_t op;
	logic isCtrlAddr;
	logic busy; // Ext or control access answering this cycle
	logic curWrite;
	logic issue;

	assign isCtrlAddr = mainAddr inside {boardMapPkg::nmiAckAddr, boardMapPkg::firqAckAddr,
		boardMapPkg::irqAckAddr, boardMapPkg::subIrqAddr};

	//******************************
	// Region decode
	//******************************
	always_comb begin
		if (mainAddr < boardMapPkg::mapBase) region = boardMapPkg::regRam;
		else if (mainAddr < boardMapPkg::back1Base) region = boardMapPkg::regMap;
		else if (mainAddr < boardMapPkg::back2Base) region = boardMapPkg::regBack1;
		else if (mainAddr < boardMapPkg::objBase) region = boardMapPkg::regBack2;
		else if (mainAddr < boardMapPkg::ioBase) region = boardMapPkg::regObj;
		else if (mainAddr < boardMapPkg::palBase) begin
			// Strobe writes never reach the I/O select
			region = (mainWrite && isCtrlAddr) ? boardMapPkg::regCtrl : boardMapPkg::regIo;
		end else if (mainAddr < boardMapPkg::romBase) region = boardMapPkg::regPal;
		else region = boardMapPkg::regRom;
	end

	always_comb begin
		case (mainAddr)
			boardMapPkg::nmiAckAddr: op = boardBusPkg::nmiAck;
			boardMapPkg::firqAckAddr: op = boardBusPkg::firqAck;
			boardMapPkg::irqAckAddr: op = boardBusPkg::irqAck;
			default: op = boardBusPkg::subIrqRaise; // 0x3A0C
		endcase
	end

	assign issue = mainValid && !busy && region != boardMapPkg::regRam; // Once per request

	always_ff @(posedge clk) begin
		if (reset) busy <= 1'b0;
		else busy <= issue;
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			curRegion <= region;
			curWrite <= mainWrite;
			extWdata <= mainWdata;
			ctrlOp <= op;
			ctrlData <= mainWdata[0];
		end
	end

	// One cycle selects, answered the cycle after valid
	assign mapSel = busy && curRegion == boardMapPkg::regMap;
	assign back1Sel = busy && curRegion == boardMapPkg::regBack1;
	assign back2Sel = busy && curRegion == boardMapPkg::regBack2;
	assign objSel = busy && curRegion == boardMapPkg::regObj;
	assign ioSel = busy && curRegion == boardMapPkg::regIo;
	assign palSel = busy && curRegion == boardMapPkg::regPal;
	assign romSel = busy && curRegion == boardMapPkg::regRom;
	assign extWrite = busy && curWrite && curRegion != boardMapPkg::regCtrl;
	assign ctrlValid = busy && curRegion == boardMapPkg::regCtrl;

	// Shared RAM goes straight to the arbiter
	assign ram.valid = mainValid && region == boardMapPkg::regRam;
	assign ram.write = mainWrite;
	assign ram.addr = mainAddr;
	assign ram.wdata = mainWdata;

	assign mainReady = busy || ram.ready;
	assign mainRdata = ram.ready ? ram.rdata : extRdata; // Ext data sampled with select

endmodule

`default_nettype wire

//--- hdl/cpuBus.sv
// CPU request bus
// Valid/ready link from a CPU decoder to the shared SRAM arbiter
`default_nettype none
`timescale 1ns/1ps

interface cpuBus;

	logic valid; // Held with its fields until ready
	logic write;
	boardBusPkg::addr_t addr;
	boardBusPkg::data_t wdata;
	boardBusPkg::data_t rdata; // Valid with ready
	logic ready; // Single cycle pulse

	modport requester (output valid, write, addr, wdata, input rdata, ready);
	modport server (input valid, write, addr, wdata, output rdata, ready);

endinterface

`default_nettype wire

//--- hdl/boardMapPkg.sv
// Board address map package
// Main and sub CPU memory maps and the main region classes
`default_nettype none

package boardMapPkg;

	// Shared RAM, same window on both CPUs
	localparam boardBusPkg::addr_t ramTop = 16'h1FFF;

	//******************************
	// Main CPU map
	//******************************
	localparam boardBusPkg::addr_t mapBase = 16'h2000;   // 2K blocks
	localparam boardBusPkg::addr_t back1Base = 16'h2800;
	localparam boardBusPkg::addr_t back2Base = 16'h3000;
	localparam boardBusPkg::addr_t objBase = 16'h3800;   // 512 byte blocks
	localparam boardBusPkg::addr_t ioBase = 16'h3A00;
	localparam boardBusPkg::addr_t palBase = 16'h3C00;   // Up to 0x3FFF
	localparam boardBusPkg::addr_t romBase = 16'h4000;   // Up to 0xFFFF

	// Interrupt strobes inside the I/O block
	localparam boardBusPkg::addr_t nmiAckAddr = 16'h3A09;
	localparam boardBusPkg::addr_t firqAckAddr = 16'h3A0A;
	localparam boardBusPkg::addr_t irqAckAddr = 16'h3A0B;
	localparam boardBusPkg::addr_t subIrqAddr = 16'h3A0C;

	//******************************
	// Sub CPU control blocks, 2K each
	//******************************
	localparam boardBusPkg::addr_t mainIrqBase = 16'h2000;
	localparam boardBusPkg::addr_t subIrqAckBase = 16'h2800;
	localparam boardBusPkg::addr_t bankBase = 16'h3000;

	typedef enum logic [3:0] {
		regRam, regMap, regBack1, regBack2, regObj,
		regIo, regPal, regRom, regCtrl
	} mainRegion_t;

endpackage

`default_nettype wire

//--- hdl/boardBusPkg.sv
// Board bus package
// CPU bus widths, data types and the arbiter and control op encodings
`default_nettype none

package boardBusPkg;

	localparam int addrW = 16; // 6809 address space
	localparam int dataW = 8;
	localparam int ramAddrW = 13; // 8K shared SRAM

	typedef logic [addrW-1:0] addr_t;
	typedef logic [dataW-1:0] data_t;
	typedef logic [ramAddrW-1:0] ramAddr_t;

	localparam data_t busIdle = 8'hFF; // Undriven bus reads as all ones

	// Shared SRAM arbiter, one serve cycle per grant
	typedef enum logic {
		arbIdle,
		arbServe
	} arbState_t;

	// Control operations raised by the decoders
	typedef enum logic [2:0] {
		nmiAck,       // Main clears NMI
		irqAck,       // Main clears IRQ
		firqAck,      // Main clears FIRQ
		subIrqRaise,  // Main interrupts sub
		mainIrqRaise, // Sub interrupts main
		subIrqAck,    // Sub clears its IRQ
		bankLoad      // Sub ROM bank bit
	} ctrlOp_t;

endpackage

`default_nettype wire
